/* include/qspi_link_config.svh */
`ifndef QSPI_LINK_CONFIG_SVH
`define QSPI_LINK_CONFIG_SVH

// ======================================================================
// Command framing
// ======================================================================

// 8-bit type followed by a 24-bit argument
`define QL_CMD_BITS 32

// Dummy byte sent ahead of every command, two nibbles on d[3:0]
`define QL_DUMMY_NIBBLES 2

// ======================================================================
// Readout FIFO
// ======================================================================

`define QL_FIFO_DEPTH 256

// Address bits plus one wrap bit
`define QL_PTR_BITS 9
`define QL_ADDR_BITS (`QL_PTR_BITS - 1)

// Bytes per readout command
`define QL_CHUNK_LEN 64

`endif

/* logic/qspi_link_pkg.sv */
`include "qspi_link_config.svh"

package qspi_link_pkg;

    // ==================================================================
    // Plain vector types
    // ==================================================================

    typedef logic [7:0] byte_t;
    typedef logic [3:0] nibble_t;
    typedef logic [3:0] led_t;
    typedef logic [`QL_CMD_BITS-9:0] msg_arg_t;
    typedef logic [`QL_PTR_BITS-1:0] fifo_ptr_t;

    // ==================================================================
    // Command encoding
    // ==================================================================

    // Top bit is always 1, the host cannot send it
    typedef enum logic [7:0] {
        echo    = 8'h80,
        led_set = 8'h81,
        readout = 8'h82,
        nop     = 8'h83
    } msg_kind_t;

    typedef struct packed {
        msg_kind_t kind;
        msg_arg_t  arg;
    } qspi_cmd_t;

    // SPI-domain sequencer
    typedef enum logic [2:0] {
        msg_start,
        msg_shift,
        decode,
        resp_out,
        rd_wait,
        rd_stream,
        idle
    } spi_state_t;

endpackage

/* logic/qspi_cycle_counter.sv */
`timescale 1ns/1ps

module qspi_cycle_counter (
    input  logic                  ice_st_spi_clk,
    input  logic                  spi_cs,
    input  logic                  load,
    input  qspi_link_pkg::byte_t  load_value,
    output logic                  zero
);
    import qspi_link_pkg::*;

    byte_t count;

    // Load wins over counting, the count holds once it reaches zero
    always_ff @(posedge ice_st_spi_clk or negedge spi_cs) begin
        if (!spi_cs) begin
            count <= '0;
        end else if (load) begin
            count <= load_value;
        end else if (count != '0) begin
            count <= count - byte_t'(1);
        end
    end

    assign zero = (count == '0);

endmodule

/* logic/qspi_shift_io.sv */
`timescale 1ns/1ps
`include "qspi_link_config.svh"

module qspi_shift_io (
    input  logic                      ice_st_spi_clk,
    input  logic                      spi_cs,
    input  qspi_link_pkg::byte_t      d_in,
    output qspi_link_pkg::qspi_cmd_t  cmd,
    input  logic                      out_load,
    input  qspi_link_pkg::byte_t      out_byte,
    input  logic                      out_en,
    output qspi_link_pkg::byte_t      d_out,
    output logic                      d_oe
);
    import qspi_link_pkg::*;

    // Dummy byte plus the command word
    localparam int shift_bits = `QL_CMD_BITS + 4 * `QL_DUMMY_NIBBLES;

    logic [shift_bits-1:0]   shift_q;
    nibble_t                 nib_in;
    logic [`QL_CMD_BITS-1:0] cmd_raw;

    // ==================================================================
    // Command input
    // ==================================================================

    // Commands arrive on the low four lines only
    assign nib_in = d_in[3:0];

    // Free-running shifter, MSB first; the FSM decides when it is valid
    always_ff @(posedge ice_st_spi_clk) begin
        shift_q <= {shift_q[shift_bits-5:0], nib_in};
    end

    // The dummy byte falls off the top once the command is complete
    assign cmd_raw = shift_q[`QL_CMD_BITS-1:0];

    // Host cannot drive the top bit of the type, so it is forced here
    assign cmd = qspi_cmd_t'({1'b1, cmd_raw[`QL_CMD_BITS-2:0]});

    // ==================================================================
    // Response output
    // ==================================================================

    // Launch register for the 8-bit response bus
    always_ff @(posedge ice_st_spi_clk) begin
        if (out_load) begin
            d_out <= out_byte;
        end
    end

    // Output enable follows the FSM one edge later, like the data
    always_ff @(posedge ice_st_spi_clk or negedge spi_cs) begin
        if (!spi_cs) begin
            d_oe <= 1'b0;
        end else begin
            d_oe <= out_en;
        end
    end

endmodule

/* logic/qspi_cmd_fsm.sv */
`timescale 1ns/1ps
`include "qspi_link_config.svh"

module qspi_cmd_fsm (
    input  logic                      ice_st_spi_clk,
    input  logic                      spi_cs,
    input  logic                      sys_rst_n,
    input  qspi_link_pkg::qspi_cmd_t  cmd,
    output logic                      cnt_load,
    output qspi_link_pkg::byte_t      cnt_value,
    input  logic                      cnt_zero,
    output logic                      out_load,
    output qspi_link_pkg::byte_t      out_byte,
    output logic                      out_en,
    output logic                      rd_en,
    input  qspi_link_pkg::byte_t      rd_data,
    input  logic                      rd_empty,
    input  logic                      rd_chunk_ready,
    output logic                      start_toggle,
    output qspi_link_pkg::led_t       leds
);
    import qspi_link_pkg::*;

    // Dummy plus command nibbles, minus the edge spent in msg_start
    localparam byte_t msg_count   = byte_t'(`QL_CMD_BITS / 4 + `QL_DUMMY_NIBBLES - 1);
    localparam byte_t chunk_count = byte_t'(`QL_CHUNK_LEN - 1);
    localparam int    arg_bits    = $bits(msg_arg_t);

    spi_state_t state;
    msg_arg_t   resp;

    // ==================================================================
    // Sequencer, restarts on every select
    // ==================================================================

    always_ff @(posedge ice_st_spi_clk or negedge spi_cs) begin
        if (!spi_cs) begin
            state <= msg_start;
        end else begin
            case (state)
                msg_start: state <= msg_shift;
                msg_shift: begin
                    if (cnt_zero) begin
                        state <= decode;
                    end
                end
                decode: begin
                    case (cmd.kind)
                        echo:    state <= resp_out;
                        readout: state <= rd_wait;
                        default: state <= idle;
                    endcase
                end
                // Chunk is only streamed once it is fully in the FIFO
                rd_wait: begin
                    if (rd_chunk_ready) begin
                        state <= rd_stream;
                    end
                end
                rd_stream: begin
                    if (cnt_zero) begin
                        state <= idle;
                    end
                end
                default: state <= state;
            endcase
        end
    end

    // Echo response, sent high byte first with zeros shifted in behind
    always_ff @(posedge ice_st_spi_clk) begin
        if (state == decode) begin
            resp <= cmd.arg;
        end else if (state == resp_out) begin
            resp <= {resp[arg_bits-9:0], 8'h00};
        end
    end

    // LEDs and the producer start flag outlive a deselect
    always_ff @(posedge ice_st_spi_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            leds         <= '0;
            start_toggle <= 1'b0;
        end else if (state == decode) begin
            if (cmd.kind == led_set) begin
                leds <= led_t'(cmd.arg);
            end
            if (cmd.kind == readout) begin
                start_toggle <= ~start_toggle;
            end
        end
    end

    // ==================================================================
    // Counter, output and FIFO controls
    // ==================================================================

    always_comb begin
        cnt_load  = 1'b0;
        cnt_value = msg_count;
        out_load  = 1'b0;
        out_byte  = '0;
        out_en    = 1'b0;
        rd_en     = 1'b0;
        case (state)
            msg_start: cnt_load = 1'b1;
            rd_wait: begin
                cnt_load  = rd_chunk_ready;
                cnt_value = chunk_count;
            end
            resp_out: begin
                out_load = 1'b1;
                out_byte = resp[arg_bits-1 -: 8];
                out_en   = 1'b1;
            end
            rd_stream: begin
                out_load = 1'b1;
                out_byte = rd_data;
                out_en   = 1'b1;
                rd_en    = !rd_empty;
            end
            default: cnt_load = 1'b0;
        endcase
    end

endmodule

/* logic/pattern_producer.sv */
`timescale 1ns/1ps
`include "qspi_link_config.svh"

module pattern_producer (
    input  logic                  prod_clk,
    input  logic                  sys_rst_n,
    input  logic                  start_toggle,
    input  logic                  wr_chunk_room,
    output logic                  wr_en,
    output qspi_link_pkg::byte_t  wr_data
);
    import qspi_link_pkg::*;

    localparam byte_t last_value = byte_t'(`QL_CHUNK_LEN - 1);

    // Two synchronizer stages plus one for edge detection
    logic [2:0] start_sync;
    logic       start_pulse;
    logic       running;

    assign start_pulse = start_sync[2] ^ start_sync[1];

    always_ff @(posedge prod_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            start_sync <= '0;
            running    <= 1'b0;
            wr_en      <= 1'b0;
            wr_data    <= '0;
        end else begin
            start_sync <= {start_sync[1:0], start_toggle};

            // Later readout commands find it already running
            if (start_pulse) begin
                running <= 1'b1;
            end

            // A chunk only starts when the whole chunk fits
            if (wr_en) begin
                if (wr_data == last_value) begin
                    wr_en <= 1'b0;
                end else begin
                    wr_data <= wr_data + byte_t'(1);
                end
            end else if (running && wr_chunk_room) begin
                wr_en   <= 1'b1;
                wr_data <= '0;
            end
        end
    end

endmodule

/* logic/byte_async_fifo.sv */
`timescale 1ns/1ps
`include "qspi_link_config.svh"

module byte_async_fifo (
    input  logic                  sys_rst_n,
    input  logic                  prod_clk,
    input  logic                  wr_en,
    input  qspi_link_pkg::byte_t  wr_data,
    output logic                  wr_chunk_room,
    input  logic                  ice_st_spi_clk,
    input  logic                  rd_en,
    output qspi_link_pkg::byte_t  rd_data,
    output logic                  rd_empty,
    output logic                  rd_chunk_ready
);
    import qspi_link_pkg::*;

    function automatic fifo_ptr_t gray_to_bin(input fifo_ptr_t gray);
        fifo_ptr_t bin;
        int        i;
        bin[`QL_PTR_BITS-1] = gray[`QL_PTR_BITS-1];
        for (i = `QL_PTR_BITS - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

    byte_t     mem [`QL_FIFO_DEPTH];

    fifo_ptr_t wr_bin, wr_bin_next, wr_gray;
    fifo_ptr_t rd_bin, rd_bin_next, rd_gray;
    fifo_ptr_t rd_gray_s1, rd_gray_s2;
    fifo_ptr_t wr_gray_s1, wr_gray_s2;
    fifo_ptr_t wr_fill, rd_fill;
    logic      wr_full, wr_do, rd_do;

    // ==================================================================
    // Write side, producer clock
    // ==================================================================

    // Fill seen here is never below the true fill
    assign wr_fill       = wr_bin - gray_to_bin(rd_gray_s2);
    assign wr_full       = (wr_fill == fifo_ptr_t'(`QL_FIFO_DEPTH));
    assign wr_do         = wr_en && !wr_full;
    assign wr_bin_next   = wr_bin + fifo_ptr_t'(wr_do);
    assign wr_chunk_room = (wr_fill <= fifo_ptr_t'(`QL_FIFO_DEPTH - `QL_CHUNK_LEN));

    always_ff @(posedge prod_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            wr_bin     <= '0;
            wr_gray    <= '0;
            rd_gray_s1 <= '0;
            rd_gray_s2 <= '0;
        end else begin
            wr_bin     <= wr_bin_next;
            wr_gray    <= wr_bin_next ^ (wr_bin_next >> 1);
            rd_gray_s1 <= rd_gray;
            rd_gray_s2 <= rd_gray_s1;
        end
    end

    always_ff @(posedge prod_clk) begin
        if (wr_do) begin
            mem[wr_bin[`QL_ADDR_BITS-1:0]] <= wr_data;
        end
    end

    // ==================================================================
    // Read side, SPI clock
    // ==================================================================

    // Fill seen here is never above the true fill
    assign rd_fill        = gray_to_bin(wr_gray_s2) - rd_bin;
    assign rd_empty       = (rd_fill == '0);
    assign rd_do          = rd_en && !rd_empty;
    assign rd_bin_next    = rd_bin + fifo_ptr_t'(rd_do);
    assign rd_chunk_ready = (rd_fill >= fifo_ptr_t'(`QL_CHUNK_LEN));

    // Head byte is visible without a read strobe
    assign rd_data = mem[rd_bin[`QL_ADDR_BITS-1:0]];

    always_ff @(posedge ice_st_spi_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            rd_bin     <= '0;
            rd_gray    <= '0;
            wr_gray_s1 <= '0;
            wr_gray_s2 <= '0;
        end else begin
            rd_bin     <= rd_bin_next;
            rd_gray    <= rd_bin_next ^ (rd_bin_next >> 1);
            wr_gray_s1 <= wr_gray;
            wr_gray_s2 <= wr_gray_s1;
        end
    end

endmodule

/* logic/qspi_link_top.sv */
`timescale 1ns/1ps

module qspi_link_top (
    input  logic                  ice_st_spi_clk,
    input  logic                  spi_cs,
    input  logic                  prod_clk,
    input  logic                  sys_rst_n,
    input  qspi_link_pkg::byte_t  d_in,
    output qspi_link_pkg::byte_t  d_out,
    output logic                  d_oe,
    output logic                  d_ready,
    output qspi_link_pkg::led_t   leds
);
    // ==================================================================
    // SPI domain
    // ==================================================================

    qspi_link_pkg::qspi_cmd_t  cmd;
    qspi_link_pkg::byte_t      cnt_value;
    qspi_link_pkg::byte_t      out_byte;
    qspi_link_pkg::byte_t      rd_data;
    logic                      cnt_load;
    logic                      cnt_zero;
    logic                      out_load;
    logic                      out_en;
    logic                      rd_en;
    logic                      rd_empty;
    logic                      start_toggle;

    // Producer domain
    qspi_link_pkg::byte_t      wr_data;
    logic                      wr_en;
    logic                      wr_chunk_room;

    qspi_shift_io shift_io0 (
        .ice_st_spi_clk (ice_st_spi_clk),
        .spi_cs         (spi_cs),
        .d_in           (d_in),
        .cmd            (cmd),
        .out_load       (out_load),
        .out_byte       (out_byte),
        .out_en         (out_en),
        .d_out          (d_out),
        .d_oe           (d_oe)
    );

    qspi_cycle_counter cycle_counter0 (
        .ice_st_spi_clk (ice_st_spi_clk),
        .spi_cs         (spi_cs),
        .load           (cnt_load),
        .load_value     (cnt_value),
        .zero           (cnt_zero)
    );

    // The chunk-ready flag doubles as the host's d_ready line
    qspi_cmd_fsm cmd_fsm0 (
        .ice_st_spi_clk (ice_st_spi_clk),
        .spi_cs         (spi_cs),
        .sys_rst_n      (sys_rst_n),
        .cmd            (cmd),
        .cnt_load       (cnt_load),
        .cnt_value      (cnt_value),
        .cnt_zero       (cnt_zero),
        .out_load       (out_load),
        .out_byte       (out_byte),
        .out_en         (out_en),
        .rd_en          (rd_en),
        .rd_data        (rd_data),
        .rd_empty       (rd_empty),
        .rd_chunk_ready (d_ready),
        .start_toggle   (start_toggle),
        .leds           (leds)
    );

    // ==================================================================
    // Clock crossing and producer
    // ==================================================================

    byte_async_fifo fifo0 (
        .sys_rst_n      (sys_rst_n),
        .prod_clk       (prod_clk),
        .wr_en          (wr_en),
        .wr_data        (wr_data),
        .wr_chunk_room  (wr_chunk_room),
        .ice_st_spi_clk (ice_st_spi_clk),
        .rd_en          (rd_en),
        .rd_data        (rd_data),
        .rd_empty       (rd_empty),
        .rd_chunk_ready (d_ready)
    );

    pattern_producer producer0 (
        .prod_clk       (prod_clk),
        .sys_rst_n      (sys_rst_n),
        .start_toggle   (start_toggle),
        .wr_chunk_room  (wr_chunk_room),
        .wr_en          (wr_en),
        .wr_data        (wr_data)
    );

endmodule

/* bench/qspi_link_tb.sv */
`timescale 1ns/1ps
`include "qspi_link_config.svh"

module qspi_link_tb;
    import qspi_link_pkg::*;

    // Generous bound for the producer to fill a chunk and cross domains
    localparam int wait_limit = 2000;

    logic   ice_st_spi_clk;
    logic   prod_clk;
    logic   spi_cs;
    logic   sys_rst_n;
    byte_t  d_in;
    byte_t  d_out;
    logic   d_oe;
    logic   d_ready;
    led_t   leds;

    integer seed;
    int     checks;
    int     errors;
    int     timeouts;
    led_t   led_expect;

    qspi_link_top dut0 (
        .ice_st_spi_clk (ice_st_spi_clk),
        .spi_cs         (spi_cs),
        .prod_clk       (prod_clk),
        .sys_rst_n      (sys_rst_n),
        .d_in           (d_in),
        .d_out          (d_out),
        .d_oe           (d_oe),
        .d_ready        (d_ready),
        .leds           (leds)
    );

    initial begin
        ice_st_spi_clk = 1'b0;
        forever #5 ice_st_spi_clk = ~ice_st_spi_clk;
    end

    // Producer clock runs unrelated to the SPI clock
    initial begin
        prod_clk = 1'b0;
        forever #3.5 prod_clk = ~prod_clk;
    end

    // ======================================================================
    // Compare tasks
    // ======================================================================

    task automatic check_byte(input byte_t got, input byte_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s, got %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_leds(input led_t got, input led_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s, got %01h, expected %01h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
        end
    endtask

    // ======================================================================
    // Host side
    // ======================================================================

    // Inputs change 1 ns after the edge
    task automatic step_edge();
        @(posedge ice_st_spi_clk);
        #1;
    endtask

    // Outputs are sampled just before the following edge
    task automatic settle_edge();
        @(posedge ice_st_spi_clk);
        #8;
    endtask

    task automatic send_cmd(input msg_kind_t kind, input msg_arg_t arg);
        qspi_cmd_t               word;
        logic [`QL_CMD_BITS-1:0] bits;
        int                      i;
        word.kind = kind;
        word.arg  = arg;
        bits      = word;
        // The host has no way to send the top bit of the type
        bits[`QL_CMD_BITS-1] = 1'b0;
        step_edge();
        spi_cs = 1'b1;
        // Edge 1 is msg_start and nibbles enter on edges 2 to 11
        step_edge();
        for (i = 0; i < `QL_DUMMY_NIBBLES; i++) begin
            d_in = 8'h00;
            step_edge();
        end
        for (i = `QL_CMD_BITS / 4 - 1; i >= 0; i--) begin
            d_in = {4'h0, bits[4*i +: 4]};
            step_edge();
        end
        // Decode edge
        step_edge();
    endtask

    task automatic deselect();
        step_edge();
        spi_cs = 1'b0;
        d_in   = '0;
        step_edge();
        step_edge();
    endtask

    // Argument bytes come back high byte first
    task automatic collect_echo(input msg_arg_t arg, input int count);
        int i;
        for (i = 0; i < count; i++) begin
            settle_edge();
            check_flag(d_oe, 1'b1, $sformatf("d_oe on echo byte %0d", i));
            check_byte(d_out, arg[$bits(msg_arg_t)-1-8*i -: 8],
                       $sformatf("echo byte %0d of arg %06h", i, arg));
        end
    endtask

    task automatic wait_for_oe(output logic seen);
        int n;
        seen = 1'b0;
        for (n = 0; n < wait_limit && !seen; n++) begin
            settle_edge();
            seen = d_oe;
        end
        if (!seen) begin
            timeouts++;
            $display("Timeout: d_oe did not go high within %0d SPI cycles", wait_limit);
        end
    endtask

    task automatic wait_for_ready(output logic seen);
        int n;
        seen = 1'b0;
        for (n = 0; n < wait_limit && !seen; n++) begin
            settle_edge();
            seen = d_ready;
        end
        if (!seen) begin
            timeouts++;
            $display("Timeout: d_ready did not rise within %0d SPI cycles", wait_limit);
        end
    endtask

    // First high d_oe already carries byte 0 of the chunk
    task automatic read_chunk(input int index);
        logic seen;
        int   i;
        send_cmd(readout, msg_arg_t'(0));
        wait_for_oe(seen);
        if (seen) begin
            for (i = 0; i < `QL_CHUNK_LEN; i++) begin
                if (i > 0) begin
                    settle_edge();
                end
                check_flag(d_oe, 1'b1, $sformatf("d_oe in readout %0d byte %0d", index, i));
                check_byte(d_out, byte_t'(i), $sformatf("readout %0d byte %0d", index, i));
            end
            settle_edge();
            check_flag(d_oe, 1'b0, $sformatf("d_oe after readout %0d", index));
        end
        deselect();
    endtask

    // ======================================================================
    // Directed tests
    // ======================================================================

    task automatic after_reset();
        check_flag(d_oe, 1'b0, "d_oe after reset");
        check_leds(leds, 4'h0, "leds after reset");
        check_flag(d_ready, 1'b0, "d_ready before any readout");
    endtask

    task automatic echo_random_args();
        msg_arg_t arg;
        repeat (3) begin
            arg = msg_arg_t'($random(seed));
            send_cmd(echo, arg);
            collect_echo(arg, 3);
            // Zeros trail the argument
            settle_edge();
            check_byte(d_out, 8'h00, "byte after the echo");
            deselect();
        end
    endtask

    task automatic led_set_and_nop(input msg_arg_t value);
        led_expect = value[3:0];
        send_cmd(led_set, value);
        deselect();
        check_leds(leds, led_expect, "leds after led_set");
        send_cmd(nop, msg_arg_t'($random(seed)));
        repeat (4) begin
            settle_edge();
            check_flag(d_oe, 1'b0, "d_oe during nop");
        end
        deselect();
        check_leds(leds, led_expect, "leds after nop");
        check_flag(d_ready, 1'b0, "d_ready before any readout");
    endtask

    task automatic repeated_readouts();
        logic ready;
        int   n;
        for (n = 1; n <= 3; n++) begin
            wait_for_ready(ready);
            if (ready) begin
                read_chunk(n);
            end
        end
    endtask

    task automatic deselect_mid_echo();
        msg_arg_t first;
        msg_arg_t second;
        logic     ready;
        first  = msg_arg_t'($random(seed));
        second = msg_arg_t'($random(seed));
        send_cmd(echo, first);
        collect_echo(first, 1);
        deselect();
        send_cmd(echo, second);
        collect_echo(second, 3);
        deselect();
        check_leds(leds, led_expect, "leds after an interrupted echo");
        // The FIFO still hands out whole counting chunks
        wait_for_ready(ready);
        if (ready) begin
            read_chunk(4);
        end
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================

    initial begin
        seed       = 63;
        checks     = 0;
        errors     = 0;
        timeouts   = 0;
        led_expect = '0;
        spi_cs     = 1'b0;
        sys_rst_n  = 1'b0;
        d_in       = '0;

        repeat (3) @(posedge ice_st_spi_clk);
        #1;
        sys_rst_n = 1'b1;

        after_reset();
        echo_random_args();
        led_set_and_nop(24'h00000a);
        led_set_and_nop(24'h123455);
        read_chunk(0);
        repeated_readouts();
        deselect_mid_echo();

        $display("Summary: %0d checks, %0d value errors, %0d timeouts",
                 checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* qspi_link.f */
+incdir+include
logic/qspi_link_pkg.sv
logic/qspi_cycle_counter.sv
logic/qspi_shift_io.sv
logic/qspi_cmd_fsm.sv
logic/pattern_producer.sv
logic/byte_async_fifo.sv
logic/qspi_link_top.sv
bench/qspi_link_tb.sv
